/* all.f */
design/spi_bridge_pkg.sv
design/spi_cmd_if.sv
design/sync_fifo.sv
design/axi_lite_regs.sv
design/spi_cmd_decode.sv
design/spi_shift_engine.sv
design/spi_result_collect.sv
design/spi_bridge_top.sv
sim/spi_periph_model.sv
sim/tb_spi_bridge.sv

/* design/axi_lite_regs.sv */
// axi4-lite slave front end
// turns bus writes and reads into per-register strobes, always answers okay
`timescale 1ns/1ps

module axi_lite_regs import spi_bridge_pkg::*; (
  input  logic                      S_AXI_ACLK,
  input  logic                      S_AXI_ARESETN,
  input  logic [AXI_ADDR_W-1:0]     S_AXI_AWADDR,
  input  logic [2:0]                S_AXI_AWPROT,
  input  logic                      S_AXI_AWVALID,
  output logic                      S_AXI_AWREADY,
  input  logic [AXI_DATA_W-1:0]     S_AXI_WDATA,
  input  logic [AXI_DATA_W/8-1:0]   S_AXI_WSTRB,
  input  logic                      S_AXI_WVALID,
  output logic                      S_AXI_WREADY,
  output logic [1:0]                S_AXI_BRESP,
  output logic                      S_AXI_BVALID,
  input  logic                      S_AXI_BREADY,
  input  logic [AXI_ADDR_W-1:0]     S_AXI_ARADDR,
  input  logic [2:0]                S_AXI_ARPROT,
  input  logic                      S_AXI_ARVALID,
  output logic                      S_AXI_ARREADY,
  output logic [AXI_DATA_W-1:0]     S_AXI_RDATA,
  output logic [1:0]                S_AXI_RRESP,
  output logic                      S_AXI_RVALID,
  input  logic                      S_AXI_RREADY,
  output logic [AXI_DATA_W-1:0]     reg_wdata,
  output logic [REG_N-1:0]          reg_wr_strobe,
  output logic [REG_N-1:0]          reg_rd_strobe,
  input  logic [AXI_DATA_W-1:0]     reg_rdata [REG_N]
);

  logic                  wr_hs;
  logic                  rd_hs;
  logic [2:0]            aw_idx;
  logic [2:0]            ar_idx;
  logic [2:0]            rd_idx_q;
  logic [AXI_DATA_W-1:0] rd_sel;

  // prot signals carry no meaning for this register bank
  assign aw_idx = S_AXI_AWADDR[REG_IDX_HI:REG_IDX_LO];
  assign ar_idx = S_AXI_ARADDR[REG_IDX_HI:REG_IDX_LO];

  // address and data are taken together in one cycle
  assign S_AXI_WREADY = S_AXI_AWREADY;
  assign wr_hs = S_AXI_AWREADY & S_AXI_AWVALID & S_AXI_WVALID;
  assign rd_hs = S_AXI_ARREADY & S_AXI_ARVALID;

  assign S_AXI_BRESP = AXI_OKAY;
  assign S_AXI_RRESP = AXI_OKAY;

  ////////////////////////////////////////////////////////////////////////////
  // write channel

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      S_AXI_AWREADY <= 1'b0;
      S_AXI_BVALID  <= 1'b0;
      reg_wr_strobe <= '0;
    end else begin
      // one cycle ready pulse, held off while a response is pending
      S_AXI_AWREADY <= ~S_AXI_AWREADY & ~S_AXI_BVALID & S_AXI_AWVALID & S_AXI_WVALID;
      reg_wr_strobe <= '0;
      if (wr_hs) begin
        S_AXI_BVALID <= 1'b1;
        // partial strobes complete on the bus but touch nothing
        if (&S_AXI_WSTRB) begin
          reg_wr_strobe <= REG_N'(1) << aw_idx;
        end
      end else if (S_AXI_BVALID && S_AXI_BREADY) begin
        S_AXI_BVALID <= 1'b0;
      end
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (wr_hs) begin
      reg_wdata <= S_AXI_WDATA;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read channel

  // unused index 7 falls through to zero
  always_comb begin
    rd_sel = '0;
    for (int i = 0; i < REG_N; i++) begin
      if (ar_idx == i[2:0]) begin
        rd_sel = reg_rdata[i];
      end
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      S_AXI_ARREADY <= 1'b0;
      S_AXI_RVALID  <= 1'b0;
      rd_idx_q      <= '0;
    end else begin
      S_AXI_ARREADY <= ~S_AXI_ARREADY & ~S_AXI_RVALID & S_AXI_ARVALID;
      if (rd_hs) begin
        S_AXI_RVALID <= 1'b1;
        rd_idx_q     <= ar_idx;
      end else if (S_AXI_RVALID && S_AXI_RREADY) begin
        S_AXI_RVALID <= 1'b0;
      end
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (rd_hs) begin
      S_AXI_RDATA <= rd_sel;
    end
  end

  // read side effects happen only once the master takes the data
  assign reg_rd_strobe = (S_AXI_RVALID && S_AXI_RREADY) ? (REG_N'(1) << rd_idx_q) : '0;

endmodule

/* design/spi_bridge_pkg.sv */
// spi bridge shared constants
// bus widths, register map, frame layout and engine encodings
package spi_bridge_pkg;

  // axi4-lite bus
  localparam int AXI_DATA_W = 32;
  localparam int AXI_ADDR_W = 6;
  localparam int REG_IDX_HI = 4;
  localparam int REG_IDX_LO = 2;
  localparam logic [1:0] AXI_OKAY = 2'b00;

  // register map, one 32-bit word each
  localparam int REG_N = 7;
  localparam logic [2:0] REG_STATUS = 3'd0;
  localparam logic [2:0] REG_WR = 3'd1;
  localparam logic [2:0] REG_ADDRESS = 3'd2;
  localparam logic [2:0] REG_DATA_LEN = 3'd3;
  localparam logic [2:0] REG_OPCODE_GROUP = 3'd4;
  localparam logic [2:0] REG_WRITE_DATA = 3'd5;
  localparam logic [2:0] REG_READ_DATA = 3'd6;

  // command and read buffers
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_PTR_W = 3;
  localparam int FIFO_LVL_W = 4;

  // spi frame fields
  localparam int SPI_ADDR_W = 10;
  localparam int SPI_LEN_W = 8;
  localparam int SPI_OPG_W = 2;
  localparam int HDR_BITS = 16;
  localparam int BIT_W = 5;
  localparam logic [BIT_W-1:0] HDR_LAST = 5'd15;
  localparam logic [BIT_W-1:0] WORD_LAST = 5'd31;

  // spi clock divide, 2 aclk cycles per half period
  localparam int SPI_HALF = 2;
  localparam int DIV_W = 2;
  localparam logic [DIV_W-1:0] DIV_RISE = DIV_W'(SPI_HALF - 1);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(2 * SPI_HALF - 1);

  // engine states
  localparam logic [1:0] ENG_IDLE = 2'd0;
  localparam logic [1:0] ENG_HDR = 2'd1;
  localparam logic [1:0] ENG_DATA = 2'd2;
  localparam logic [1:0] ENG_TRAIL = 2'd3;

endpackage

/* design/spi_bridge_top.sv */
// axi4-lite to spi master bridge top level
// wires the bus slave, decode, shift engine and result stages
`timescale 1ns/1ps

module spi_bridge_top import spi_bridge_pkg::*; (
  input  logic                    S_AXI_ACLK,
  input  logic                    S_AXI_ARESETN,
  input  logic [AXI_ADDR_W-1:0]   S_AXI_AWADDR,
  input  logic [2:0]              S_AXI_AWPROT,
  input  logic                    S_AXI_AWVALID,
  output logic                    S_AXI_AWREADY,
  input  logic [AXI_DATA_W-1:0]   S_AXI_WDATA,
  input  logic [AXI_DATA_W/8-1:0] S_AXI_WSTRB,
  input  logic                    S_AXI_WVALID,
  output logic                    S_AXI_WREADY,
  output logic [1:0]              S_AXI_BRESP,
  output logic                    S_AXI_BVALID,
  input  logic                    S_AXI_BREADY,
  input  logic [AXI_ADDR_W-1:0]   S_AXI_ARADDR,
  input  logic [2:0]              S_AXI_ARPROT,
  input  logic                    S_AXI_ARVALID,
  output logic                    S_AXI_ARREADY,
  output logic [AXI_DATA_W-1:0]   S_AXI_RDATA,
  output logic [1:0]              S_AXI_RRESP,
  output logic                    S_AXI_RVALID,
  input  logic                    S_AXI_RREADY,
  output logic                    spi_clk,
  output logic                    cs_b,
  output logic                    pico,
  input  logic                    poci
);

  logic [AXI_DATA_W-1:0] reg_wdata;
  logic [REG_N-1:0]      reg_wr_strobe;
  logic [REG_N-1:0]      reg_rd_strobe;
  logic [AXI_DATA_W-1:0] reg_rdata [REG_N];
  logic [AXI_DATA_W-1:0] cfg_rdata [REG_WR:REG_WRITE_DATA];
  logic                  busy;
  logic                  rd_push;
  logic [AXI_DATA_W-1:0] rd_word;
  logic                  rd_full;
  logic [AXI_DATA_W-1:0] read_word;
  logic [FIFO_LVL_W-1:0] read_level;

  spi_cmd_if cmd ();

  axi_lite_regs u_axi (.*);

  ////////////////////////////////////////////////////////////////////////////
  // read word map, status is busy in bit 0 and buffer level in 11..8

  assign reg_rdata[REG_STATUS] = {{(AXI_DATA_W-12){1'b0}}, read_level, 7'b0, busy};
  for (genvar i = REG_WR; i <= REG_WRITE_DATA; i++) begin : g_cfg
    assign reg_rdata[i] = cfg_rdata[i];
  end
  assign reg_rdata[REG_READ_DATA] = read_word;

  spi_cmd_decode u_decode (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .reg_wdata     (reg_wdata),
    .reg_wr_strobe (reg_wr_strobe),
    .reg_rdata     (cfg_rdata),
    .busy          (busy),
    .cmd           (cmd)
  );

  spi_shift_engine u_engine (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .cmd           (cmd),
    .rd_push       (rd_push),
    .rd_word       (rd_word),
    .rd_full       (rd_full),
    .spi_clk       (spi_clk),
    .cs_b          (cs_b),
    .pico          (pico),
    .poci          (poci)
  );

  spi_result_collect u_result (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .rd_push       (rd_push),
    .rd_word       (rd_word),
    .rd_full       (rd_full),
    .busy          (busy),
    .read_strobe   (reg_rd_strobe[REG_READ_DATA]),
    .read_word     (read_word),
    .read_level    (read_level)
  );

endmodule

/* design/spi_cmd_decode.sv */
// register bank and command decode
// holds visible and shadow registers, the command buffer and the busy flag
`timescale 1ns/1ps

module spi_cmd_decode import spi_bridge_pkg::*; (
  input  logic                  S_AXI_ACLK,
  input  logic                  S_AXI_ARESETN,
  input  logic [AXI_DATA_W-1:0] reg_wdata,
  input  logic [REG_N-1:0]      reg_wr_strobe,
  output logic [AXI_DATA_W-1:0] reg_rdata [REG_WR:REG_WRITE_DATA],
  output logic                  busy,
  spi_cmd_if.decode             cmd
);

  // software visible copies
  logic                  wr_q;
  logic [SPI_ADDR_W-1:0] addr_q;
  logic [SPI_LEN_W-1:0]  len_q;
  logic [SPI_OPG_W-1:0]  opg_q;
  logic [AXI_DATA_W-1:0] wdata_q;
  // command buffer
  logic                  cmd_full;
  logic                  cmd_push;
  logic [AXI_DATA_W-1:0] cmd_head;
  logic                  cmd_none;

  assign reg_rdata[REG_WR]           = AXI_DATA_W'(wr_q);
  assign reg_rdata[REG_ADDRESS]      = AXI_DATA_W'(addr_q);
  assign reg_rdata[REG_DATA_LEN]     = AXI_DATA_W'(len_q);
  assign reg_rdata[REG_OPCODE_GROUP] = AXI_DATA_W'(opg_q);
  assign reg_rdata[REG_WRITE_DATA]   = wdata_q;

  // outgoing words queue here until the engine pops them
  assign cmd_push = reg_wr_strobe[REG_WRITE_DATA] & ~cmd_full;

  sync_fifo u_cmd_fifo (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .wr_en         (cmd_push),
    .din           (reg_wdata),
    .full          (cmd_full),
    .rd_en         (cmd.cmd_pop),
    .dout          (cmd_head),
    .empty         (cmd_none),
    .level         ()
  );

  assign cmd.cmd_word  = cmd_head;
  assign cmd.cmd_empty = cmd_none;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      wr_q             <= 1'b0;
      addr_q           <= '0;
      len_q            <= '0;
      opg_q            <= '0;
      wdata_q          <= '0;
      cmd.wnr          <= 1'b0;
      cmd.address      <= '0;
      cmd.data_len     <= '0;
      cmd.opcode_group <= '0;
      cmd.start        <= 1'b0;
      busy             <= 1'b0;
    end else begin
      cmd.start <= 1'b0;
      // shadows only follow while idle so a running frame is untouched
      if (reg_wr_strobe[REG_WR]) begin
        wr_q <= reg_wdata[0];
        if (!busy) cmd.wnr <= reg_wdata[0];
      end
      if (reg_wr_strobe[REG_ADDRESS]) begin
        addr_q <= reg_wdata[SPI_ADDR_W-1:0];
        if (!busy) cmd.address <= reg_wdata[SPI_ADDR_W-1:0];
      end
      if (reg_wr_strobe[REG_OPCODE_GROUP]) begin
        opg_q <= reg_wdata[SPI_OPG_W-1:0];
        if (!busy) cmd.opcode_group <= reg_wdata[SPI_OPG_W-1:0];
      end
      if (reg_wr_strobe[REG_WRITE_DATA]) begin
        wdata_q <= reg_wdata;
      end
      // non-zero length while idle kicks off a transfer
      if (reg_wr_strobe[REG_DATA_LEN]) begin
        len_q <= reg_wdata[SPI_LEN_W-1:0];
        if (!busy && reg_wdata[SPI_LEN_W-1:0] != '0) begin
          cmd.data_len <= reg_wdata[SPI_LEN_W-1:0];
          cmd.start    <= 1'b1;
          busy         <= 1'b1;
        end
      end
      // completion, length reads back zero
      if (cmd.done) begin
        busy  <= 1'b0;
        len_q <= '0;
      end
    end
  end

endmodule

/* design/spi_cmd_if.sv */
// command link between register decode and the spi shift engine
`timescale 1ns/1ps

interface spi_cmd_if import spi_bridge_pkg::*; ();
  // shadowed transfer fields, stable from start until done
  logic start;
  logic wnr;
  logic [SPI_ADDR_W-1:0] address;
  logic [SPI_LEN_W-1:0] data_len;
  logic [SPI_OPG_W-1:0] opcode_group;
  // command buffer read side, show-ahead
  logic [AXI_DATA_W-1:0] cmd_word;
  logic cmd_empty;
  logic cmd_pop;
  logic done;

  modport decode (
    output start, wnr, address, data_len, opcode_group, cmd_word, cmd_empty,
    input done, cmd_pop
  );
  modport engine (
    input start, wnr, address, data_len, opcode_group, cmd_word, cmd_empty,
    output done, cmd_pop
  );
endinterface

/* design/spi_result_collect.sv */
// read buffer for words received from the peripheral
`timescale 1ns/1ps

module spi_result_collect import spi_bridge_pkg::*; (
  input  logic                  S_AXI_ACLK,
  input  logic                  S_AXI_ARESETN,
  input  logic                  rd_push,
  input  logic [AXI_DATA_W-1:0] rd_word,
  output logic                  rd_full,
  input  logic                  busy,
  input  logic                  read_strobe,
  output logic [AXI_DATA_W-1:0] read_word,
  output logic [FIFO_LVL_W-1:0] read_level
);

  logic                  pop_q;
  logic [AXI_DATA_W-1:0] head;
  logic                  empty;

  // pop one cycle after the handshake, never while a frame is in flight
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      pop_q <= 1'b0;
    end else begin
      pop_q <= read_strobe & ~busy;
    end
  end

  sync_fifo u_rd_fifo (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .wr_en         (rd_push),
    .din           (rd_word),
    .full          (rd_full),
    .rd_en         (pop_q),
    .dout          (head),
    .empty         (empty),
    .level         (read_level)
  );

  // drained buffer reads as zero
  assign read_word = empty ? '0 : head;

endmodule

/* design/spi_shift_engine.sv */
// spi mode 0 shift engine, msb first
// sends a 16-bit header then data_len words, collects poci words on reads
`timescale 1ns/1ps

module spi_shift_engine import spi_bridge_pkg::*; (
  input  logic                  S_AXI_ACLK,
  input  logic                  S_AXI_ARESETN,
  spi_cmd_if.engine             cmd,
  output logic                  rd_push,
  output logic [AXI_DATA_W-1:0] rd_word,
  input  logic                  rd_full,
  output logic                  spi_clk,
  output logic                  cs_b,
  output logic                  pico,
  input  logic                  poci
);

  logic [1:0]            state_q;
  logic [DIV_W-1:0]      div_q;
  logic [BIT_W-1:0]      bit_q;
  logic [SPI_LEN_W-1:0]  word_q;
  logic [AXI_DATA_W-1:0] shift_q;
  logic [AXI_DATA_W-1:0] rx_q;
  logic [HDR_BITS-1:0]   header;
  logic [AXI_DATA_W-1:0] next_word;
  logic                  seg_end;
  logic                  last_seg;

  // opcode group, write flag, three zero bits, address
  assign header = {cmd.opcode_group, cmd.wnr, 3'b000, cmd.address};

  // reads clock out zeros, an empty buffer also sends zero
  assign next_word = (cmd.wnr && !cmd.cmd_empty) ? cmd.cmd_word : '0;
  assign seg_end   = (state_q == ENG_HDR) ? (bit_q == HDR_LAST) : (bit_q == WORD_LAST);
  assign last_seg  = (state_q == ENG_DATA) && (word_q == cmd.data_len - 1'b1);
  assign rd_word   = rx_q;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      state_q     <= ENG_IDLE;
      div_q       <= '0;
      bit_q       <= '0;
      word_q      <= '0;
      shift_q     <= '0;
      rx_q        <= '0;
      spi_clk     <= 1'b0;
      cs_b        <= 1'b1;
      pico        <= 1'b0;
      rd_push     <= 1'b0;
      cmd.cmd_pop <= 1'b0;
      cmd.done    <= 1'b0;
    end else begin
      rd_push     <= 1'b0;
      cmd.cmd_pop <= 1'b0;
      cmd.done    <= 1'b0;
      case (state_q)
        ENG_IDLE: begin
          // first header bit goes out with chip select
          if (cmd.start) begin
            state_q <= ENG_HDR;
            cs_b    <= 1'b0;
            div_q   <= '0;
            bit_q   <= '0;
            word_q  <= '0;
            pico    <= header[HDR_BITS-1];
            shift_q <= {header[HDR_BITS-2:0], {(AXI_DATA_W-HDR_BITS+1){1'b0}}};
          end
        end
        ENG_HDR, ENG_DATA: begin
          div_q <= div_q + 1'b1;
          // rising edge, sample poci
          if (div_q == DIV_RISE) begin
            spi_clk <= 1'b1;
            rx_q    <= {rx_q[AXI_DATA_W-2:0], poci};
            if (state_q == ENG_DATA && !cmd.wnr && bit_q == WORD_LAST) begin
              rd_push <= ~rd_full;
            end
          end
          // falling edge, advance pico
          if (div_q == DIV_LAST) begin
            spi_clk <= 1'b0;
            bit_q   <= bit_q + 1'b1;
            if (!seg_end) begin
              pico    <= shift_q[AXI_DATA_W-1];
              shift_q <= shift_q << 1;
            end else if (last_seg) begin
              state_q <= ENG_TRAIL;
              pico    <= 1'b0;
            end else begin
              // word boundary, load the next word from the buffer head
              state_q     <= ENG_DATA;
              bit_q       <= '0;
              word_q      <= word_q + ((state_q == ENG_DATA) ? 1'b1 : 1'b0);
              pico        <= next_word[AXI_DATA_W-1];
              shift_q     <= {next_word[AXI_DATA_W-2:0], 1'b0};
              cmd.cmd_pop <= cmd.wnr & ~cmd.cmd_empty;
            end
          end
        end
        default: begin
          // trailing gap, then cs_b high and done a cycle later
          div_q <= div_q + 1'b1;
          if (cs_b) begin
            cmd.done <= 1'b1;
            state_q  <= ENG_IDLE;
          end else if (div_q == DIV_RISE) begin
            cs_b <= 1'b1;
          end
        end
      endcase
    end
  end

endmodule

/* design/sync_fifo.sv */
// single clock show-ahead fifo
// dout always presents the head word, level counts stored words
`timescale 1ns/1ps

module sync_fifo import spi_bridge_pkg::*; (
  input  logic                  S_AXI_ACLK,
  input  logic                  S_AXI_ARESETN,
  input  logic                  wr_en,
  input  logic [AXI_DATA_W-1:0] din,
  output logic                  full,
  input  logic                  rd_en,
  output logic [AXI_DATA_W-1:0] dout,
  output logic                  empty,
  output logic [FIFO_LVL_W-1:0] level
);

  logic [AXI_DATA_W-1:0] mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic do_wr;
  logic do_rd;

  // writes into a full buffer and reads from an empty one are ignored
  assign do_wr = wr_en & ~full;
  assign do_rd = rd_en & ~empty;

  assign full  = (level == FIFO_LVL_W'(FIFO_DEPTH));
  assign empty = (level == '0);
  assign dout  = mem[rd_ptr];

  always_ff @(posedge S_AXI_ACLK) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_wr && !do_rd) begin
        level <= level + 1'b1;
      end else if (do_rd && !do_wr) begin
        level <= level - 1'b1;
      end
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# build and run the spi bridge testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_spi_bridge -f all.f -o tb_spi_bridge
out=$(./obj_dir/tb_spi_bridge)
echo "$out"
if echo "$out" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1

/* sim/spi_periph_model.sv */
// behavioral spi peripheral, mode 0 msb first
// captures header and pico words, answers read frames with a fixed word pattern
`timescale 1ns/1ps

module spi_periph_model (
  input  logic spi_clk,
  input  logic cs_b,
  input  logic pico,
  output logic poci
);

  // frame record, read back by the testbench after each transfer
  int          frames = 0;
  int          nbits = 0;
  int          nwords = 0;
  logic [15:0] hdr = '0;
  logic [31:0] rx = '0;
  logic [31:0] words [16];
  logic [31:0] reply;

  // word k of a read frame
  function automatic logic [31:0] reply_word(input int k, input logic [9:0] addr);
    return 32'hA5A5_0000 ^ (32'(k) << 12) ^ {22'd0, addr};
  endfunction

  initial poci = 1'b0;

  // frame ends on cs_b rising, bits are taken on spi_clk rising
  always @(posedge spi_clk or posedge cs_b) begin
    if (cs_b) begin
      if (nbits != 0) begin
        frames = frames + 1;
      end
      nbits = 0;
    end else begin
      if (nbits == 0) begin
        nwords = 0;
      end
      if (nbits < 16) begin
        hdr = {hdr[14:0], pico};
      end else begin
        rx = {rx[30:0], pico};
        // last bit of a data word
        if ((nbits - 16) % 32 == 31 && nwords < 16) begin
          words[nwords] = rx;
          nwords = nwords + 1;
        end
      end
      nbits = nbits + 1;
    end
  end

  // next poci bit is set up half a period ahead of its sampling edge
  always @(negedge spi_clk) begin
    if (!cs_b && nbits >= 16) begin
      reply = reply_word((nbits - 16) / 32, hdr[9:0]);
      poci = reply[31 - ((nbits - 16) % 32)];
    end
  end

endmodule

/* sim/tb_spi_bridge.sv */
// testbench for the axi4-lite spi master bridge
// register, write and read transfers from seed 64, checked against a local model
`timescale 1ns/1ps

module tb_spi_bridge import spi_bridge_pkg::*; ();

  localparam int WAIT_MAX = 32;
  localparam int POLL_MAX = 1000;

  logic                    S_AXI_ACLK = 1'b0;
  logic                    S_AXI_ARESETN;
  logic [AXI_ADDR_W-1:0]   S_AXI_AWADDR;
  logic [2:0]              S_AXI_AWPROT;
  logic                    S_AXI_AWVALID;
  logic                    S_AXI_AWREADY;
  logic [AXI_DATA_W-1:0]   S_AXI_WDATA;
  logic [AXI_DATA_W/8-1:0] S_AXI_WSTRB;
  logic                    S_AXI_WVALID;
  logic                    S_AXI_WREADY;
  logic [1:0]              S_AXI_BRESP;
  logic                    S_AXI_BVALID;
  logic                    S_AXI_BREADY;
  logic [AXI_ADDR_W-1:0]   S_AXI_ARADDR;
  logic [2:0]              S_AXI_ARPROT;
  logic                    S_AXI_ARVALID;
  logic                    S_AXI_ARREADY;
  logic [AXI_DATA_W-1:0]   S_AXI_RDATA;
  logic [1:0]              S_AXI_RRESP;
  logic                    S_AXI_RVALID;
  logic                    S_AXI_RREADY;
  logic                    spi_clk;
  logic                    cs_b;
  logic                    pico;
  logic                    poci;

  integer      seed = 64;
  int          errors = 0;
  int          tests = 0;
  int          failed_tests = 0;
  int          errs_at_start = 0;
  // words pushed for the current write transfer
  logic [31:0] sent [$];

  spi_bridge_top DUT (.*);

  spi_periph_model u_periph (
    .spi_clk (spi_clk),
    .cs_b    (cs_b),
    .pico    (pico),
    .poci    (poci)
  );

  // 4 ns clock
  always #2 S_AXI_ACLK = ~S_AXI_ACLK;

  ////////////////////////////////////////////////////////////////////////////
  // reporting

  task automatic finish_run();
    $display("tests run %0d, tests bad %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s, run stopped", what);
    errors++;
    finish_run();
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("Error %s expected %h actual %h", sig, exp, act);
    errors++;
  endtask

  task automatic begin_test();
    errs_at_start = errors;
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == errs_at_start) begin
      $display("%s: ok", name);
    end else begin
      failed_tests++;
      $display("%s: %0d errors", name, errors - errs_at_start);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // axi4-lite master

  task automatic axi_write(input logic [2:0] idx, input logic [31:0] data,
                           input logic [3:0] strb);
    int n;
    @(posedge S_AXI_ACLK);
    S_AXI_AWADDR  <= {1'b0, idx, 2'b00};
    S_AXI_WDATA   <= data;
    S_AXI_WSTRB   <= strb;
    S_AXI_AWVALID <= 1'b1;
    S_AXI_WVALID  <= 1'b1;
    n = 0;
    do begin
      @(posedge S_AXI_ACLK);
      n++;
    end while (!S_AXI_AWREADY && n < WAIT_MAX);
    if (!S_AXI_AWREADY) abort_on_timeout("AWREADY");
    // address and data are accepted in the same cycle
    if (S_AXI_WREADY !== 1'b1) report_mismatch("WREADY", 32'd1, 32'(S_AXI_WREADY));
    S_AXI_AWVALID <= 1'b0;
    S_AXI_WVALID  <= 1'b0;
    S_AXI_BREADY  <= 1'b1;
    n = 0;
    do begin
      @(posedge S_AXI_ACLK);
      n++;
    end while (!S_AXI_BVALID && n < WAIT_MAX);
    if (!S_AXI_BVALID) abort_on_timeout("BVALID");
    if (S_AXI_BRESP !== AXI_OKAY) report_mismatch("BRESP", 32'(AXI_OKAY), 32'(S_AXI_BRESP));
    S_AXI_BREADY <= 1'b0;
  endtask

  task automatic axi_read(input logic [2:0] idx, output logic [31:0] data);
    int n;
    @(posedge S_AXI_ACLK);
    S_AXI_ARADDR  <= {1'b0, idx, 2'b00};
    S_AXI_ARVALID <= 1'b1;
    n = 0;
    do begin
      @(posedge S_AXI_ACLK);
      n++;
    end while (!S_AXI_ARREADY && n < WAIT_MAX);
    if (!S_AXI_ARREADY) abort_on_timeout("ARREADY");
    S_AXI_ARVALID <= 1'b0;
    S_AXI_RREADY  <= 1'b1;
    n = 0;
    do begin
      @(posedge S_AXI_ACLK);
      n++;
    end while (!S_AXI_RVALID && n < WAIT_MAX);
    if (!S_AXI_RVALID) abort_on_timeout("RVALID");
    if (S_AXI_RRESP !== AXI_OKAY) report_mismatch("RRESP", 32'(AXI_OKAY), 32'(S_AXI_RRESP));
    data = S_AXI_RDATA;
    S_AXI_RREADY <= 1'b0;
  endtask

  task automatic read_expect(input logic [2:0] idx, input logic [31:0] exp, input string name);
    logic [31:0] r;
    axi_read(idx, r);
    if (r !== exp) report_mismatch(name, exp, r);
  endtask

  // poll STATUS busy until the frame is over
  task automatic wait_idle();
    logic [31:0] st;
    int n;
    n = 0;
    do begin
      axi_read(REG_STATUS, st);
      n++;
    end while (st[0] && n < POLL_MAX);
    if (st[0]) abort_on_timeout("STATUS busy to clear");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // model and transfers

  // read word k as the peripheral returns it
  function automatic logic [31:0] predict_read_word(input int k, input logic [9:0] addr);
    return 32'hA5A5_0000 ^ (32'(k) << 12) ^ {22'd0, addr};
  endfunction

  task automatic setup_frame(input logic wnr, input logic [9:0] addr, input logic [1:0] opg);
    axi_write(REG_WR, {31'd0, wnr}, 4'hF);
    axi_write(REG_ADDRESS, {22'd0, addr}, 4'hF);
    axi_write(REG_OPCODE_GROUP, {30'd0, opg}, 4'hF);
  endtask

  task automatic check_frame(input logic [15:0] exp_hdr, input int f0);
    if (u_periph.frames != f0 + 1) report_mismatch("frame count", 32'(f0 + 1),
                                                   32'(u_periph.frames));
    if (u_periph.hdr !== exp_hdr) report_mismatch("header", 32'(exp_hdr), 32'(u_periph.hdr));
  endtask

  task automatic run_write(input int len, input logic disturb);
    logic [31:0] rnd;
    logic [9:0]  addr;
    logic [1:0]  opg;
    int          f0;
    rnd  = $random(seed);
    addr = rnd[9:0];
    opg  = rnd[17:16];
    setup_frame(1'b1, addr, opg);
    sent.delete();
    for (int i = 0; i < len; i++) begin
      rnd = $random(seed);
      sent.push_back(rnd);
      axi_write(REG_WRITE_DATA, rnd, 4'hF);
    end
    f0 = u_periph.frames;
    axi_write(REG_DATA_LEN, 32'(len), 4'hF);
    // new fields land in the visible registers only
    if (disturb) begin
      axi_write(REG_ADDRESS, {22'd0, ~addr}, 4'hF);
      axi_write(REG_OPCODE_GROUP, {30'd0, ~opg}, 4'hF);
      axi_write(REG_DATA_LEN, 32'd5, 4'hF);
      read_expect(REG_STATUS, 32'd1, "STATUS busy");
    end
    wait_idle();
    check_frame({opg, 1'b1, 3'b000, addr}, f0);
    if (u_periph.nwords != sent.size()) report_mismatch("pico word count",
                                                        32'(sent.size()), 32'(u_periph.nwords));
    for (int i = 0; i < sent.size(); i++) begin
      if (u_periph.words[i] !== sent[i]) report_mismatch($sformatf("pico word %0d", i),
                                                         sent[i], u_periph.words[i]);
    end
    read_expect(REG_DATA_LEN, 32'd0, "DATA_LEN");
    if (disturb) begin
      read_expect(REG_ADDRESS, {22'd0, ~addr}, "ADDRESS");
      read_expect(REG_OPCODE_GROUP, {30'd0, ~opg}, "OPCODE_GROUP");
      read_expect(REG_STATUS, 32'd0, "STATUS");
      // no second frame has opened
      if (cs_b !== 1'b1) report_mismatch("cs_b", 32'd1, 32'(cs_b));
    end
  endtask

  task automatic run_read(input int len);
    logic [31:0] rnd;
    logic [9:0]  addr;
    logic [1:0]  opg;
    int          f0;
    rnd  = $random(seed);
    addr = rnd[9:0];
    opg  = rnd[17:16];
    setup_frame(1'b0, addr, opg);
    f0 = u_periph.frames;
    axi_write(REG_DATA_LEN, 32'(len), 4'hF);
    wait_idle();
    check_frame({opg, 1'b0, 3'b000, addr}, f0);
    read_expect(REG_DATA_LEN, 32'd0, "DATA_LEN");
    // level in bits 11..8 with busy low
    read_expect(REG_STATUS, 32'(len) << 8, "STATUS");
    for (int k = 0; k < len; k++) begin
      read_expect(REG_READ_DATA, predict_read_word(k, addr), "READ_DATA");
    end
    read_expect(REG_READ_DATA, 32'd0, "READ_DATA");
    read_expect(REG_STATUS, 32'd0, "STATUS");
  endtask

  task automatic test_reset_readback();
    logic [31:0] v;
    logic [31:0] keep;
    for (int i = 0; i < REG_N; i++) begin
      read_expect(3'(i), 32'd0, $sformatf("register %0d", i));
    end
    // spi pins rest with chip select high and clock low
    if (cs_b !== 1'b1) report_mismatch("cs_b", 32'd1, 32'(cs_b));
    if (spi_clk !== 1'b0) report_mismatch("spi_clk", 32'd0, 32'(spi_clk));
    if (pico !== 1'b0) report_mismatch("pico", 32'd0, 32'(pico));
    repeat (4) begin
      v = $random(seed);
      axi_write(REG_WR, v, 4'hF);
      read_expect(REG_WR, {31'd0, v[0]}, "WR");
      v = $random(seed);
      axi_write(REG_ADDRESS, v, 4'hF);
      read_expect(REG_ADDRESS, {22'd0, v[9:0]}, "ADDRESS");
      v = $random(seed);
      axi_write(REG_OPCODE_GROUP, v, 4'hF);
      read_expect(REG_OPCODE_GROUP, {30'd0, v[1:0]}, "OPCODE_GROUP");
    end
    // a partial strobe completes but changes nothing
    axi_read(REG_ADDRESS, keep);
    v = $random(seed);
    // address field differs from the held value
    v[9:0] = ~keep[9:0];
    axi_write(REG_ADDRESS, v, 4'b0111);
    read_expect(REG_ADDRESS, keep, "ADDRESS");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence

  initial begin
    logic [31:0] rnd;
    S_AXI_ARESETN = 1'b0;
    S_AXI_AWADDR  = '0;
    S_AXI_AWPROT  = '0;
    S_AXI_AWVALID = 1'b0;
    S_AXI_WDATA   = '0;
    S_AXI_WSTRB   = '0;
    S_AXI_WVALID  = 1'b0;
    S_AXI_BREADY  = 1'b0;
    S_AXI_ARADDR  = '0;
    S_AXI_ARPROT  = '0;
    S_AXI_ARVALID = 1'b0;
    S_AXI_RREADY  = 1'b0;
    repeat (2) @(posedge S_AXI_ACLK);
    S_AXI_ARESETN <= 1'b1;

    begin_test();
    test_reset_readback();
    end_test("reset and readback");

    begin_test();
    rnd = $random(seed);
    run_write(1 + int'(rnd[1:0]), 1'b0);
    end_test("write transfer");

    begin_test();
    rnd = $random(seed);
    run_read(1 + int'(rnd[7:0] % 6));
    end_test("read transfer");

    begin_test();
    run_write(2, 1'b1);
    end_test("shadowing while busy");

    begin_test();
    repeat (20) begin
      rnd = $random(seed);
      if (rnd[0]) begin
        run_write(1 + int'(rnd[9:8]), 1'b0);
      end else begin
        run_read(1 + int'(rnd[23:16] % 6));
      end
    end
    end_test("randomized sequence");

    finish_run();
  end

endmodule
